// File: hw/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [2:0] block_t;
    typedef logic [3:0] bit_cnt_t;

    // block number sits above the address byte
    typedef logic [$bits(block_t)+$bits(byte_t)-1:0] mem_addr_t;

    // top nibble of every control byte this device answers to
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    typedef enum logic [1:0]
    {
        SHIFT_IDLE,
        SHIFT_RX,
        SHIFT_TX
    } shift_mode_t;

    // single-cycle pulses, except data which is the synchronized level
    typedef struct packed
    {
        logic start;
        logic stop;
        logic clk_rise;
        logic clk_fall;
        logic data;
    } bus_event_t;

    typedef struct packed
    {
        logic      wr_en;
        logic      rd_en;
        mem_addr_t addr;
        byte_t     wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// File: hw/bus_sampler.sv
`default_nettype none

module bus_sampler #(
    parameter int SYNC_STAGES = 2
) (
    input  wire                    scl,
    input  wire                    rst_n,
    input  wire                    bus_clk,
    input  wire                    bus_data,
    output eeprom_pkg::bus_event_t events
);

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] data_sync;
    logic                   clk_s;
    logic                   data_s;
    logic                   clk_q;
    logic                   data_q;
    logic                   clk_high;

    assign clk_s    = clk_sync[SYNC_STAGES-1];
    assign data_s   = data_sync[SYNC_STAGES-1];
    // clock stable high over both samples
    assign clk_high = clk_s && clk_q;

    // both lines idle high
    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clk_sync  <= '1;
            data_sync <= '1;
        end
        else
        begin
            clk_sync  <= {clk_sync[SYNC_STAGES-2:0], bus_clk};
            data_sync <= {data_sync[SYNC_STAGES-2:0], bus_data};
        end
    end

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clk_q  <= 1'b1;
            data_q <= 1'b1;
            events <= '{start: 1'b0, stop: 1'b0, clk_rise: 1'b0, clk_fall: 1'b0, data: 1'b1};
        end
        else
        begin
            clk_q           <= clk_s;
            data_q          <= data_s;
            events.clk_rise <= clk_s && !clk_q;
            events.clk_fall <= !clk_s && clk_q;
            // data moving while the clock is high marks start or stop
            events.start    <= clk_high && data_q && !data_s;
            events.stop     <= clk_high && !data_q && data_s;
            events.data     <= data_s;
        end
    end

endmodule

`default_nettype wire

// File: hw/byte_shifter.sv
`default_nettype none

module byte_shifter (
    input  wire                     scl,
    input  wire                     rst_n,
    input  wire eeprom_pkg::bus_event_t  events,
    input  wire eeprom_pkg::shift_mode_t shift_mode,
    input  wire                     load,
    input  wire eeprom_pkg::byte_t  tx_byte,
    output eeprom_pkg::byte_t       rx_byte,
    output logic                    tx_bit,
    output logic                    byte_done
);

    eeprom_pkg::bit_cnt_t bit_cnt;
    eeprom_pkg::bit_cnt_t done_cnt;
    eeprom_pkg::byte_t    tx_reg;
    logic                 ack_slot;

    // receiving, the ninth rise is the acknowledge we drive ourselves
    assign ack_slot = (shift_mode == eeprom_pkg::SHIFT_RX) && (bit_cnt == 4'd8);
    // transmitting, the ninth rise carries the host acknowledge
    assign done_cnt = (shift_mode == eeprom_pkg::SHIFT_TX) ? 4'd8 : 4'd7;
    assign tx_bit   = tx_reg[7];

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt   <= '0;
            rx_byte   <= '0;
            tx_reg    <= '1;
            byte_done <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            if (events.start || shift_mode == eeprom_pkg::SHIFT_IDLE)
            begin
                bit_cnt <= '0;
                tx_reg  <= '1;
            end
            else if (load)
            begin
                bit_cnt <= '0;
                tx_reg  <= tx_byte;
            end
            else
            begin
                if (events.clk_rise)
                begin
                    if (ack_slot)
                    begin
                        bit_cnt <= '0;
                    end
                    else
                    begin
                        rx_byte   <= {rx_byte[6:0], events.data};
                        byte_done <= (bit_cnt == done_cnt);
                        bit_cnt   <= (bit_cnt == 4'd8) ? 4'd0 : bit_cnt + 4'd1;
                    end
                end
                // msb first, ones behind it release the line for the ack
                if (events.clk_fall && shift_mode == eeprom_pkg::SHIFT_TX)
                begin
                    tx_reg <= {tx_reg[6:0], 1'b1};
                end
            end
        end
    end

    a_done_single: assert property (@(posedge scl) disable iff (!rst_n)
        byte_done |=> !byte_done);

endmodule

`default_nettype wire

// File: hw/eeprom_ctrl.sv
`default_nettype none

module eeprom_ctrl (
    input  wire                           scl,
    input  wire                           rst_n,
    input  wire eeprom_pkg::bus_event_t   events,
    input  wire eeprom_pkg::byte_t        rx_byte,
    input  wire                           tx_bit,
    input  wire                           byte_done,
    input  wire eeprom_pkg::byte_t        rdata,
    output eeprom_pkg::shift_mode_t       shift_mode,
    output logic                          load,
    output eeprom_pkg::byte_t             tx_byte,
    output eeprom_pkg::mem_req_t          mem_req,
    output logic                          data_pull_low
);

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_CTRL,
        ST_ADDR,
        ST_DATA,
        ST_ACK,
        ST_READ_TX,
        ST_WAIT_STOP
    } state_t;

    state_t               state;
    state_t               ack_next;
    logic                 ack_drive;
    logic                 addr_valid;
    eeprom_pkg::block_t   block;
    eeprom_pkg::byte_t    addr_lo;
    logic                 code_ok;
    logic                 ack_end;

    assign code_ok = (rx_byte[7:4] == eeprom_pkg::DEVICE_CODE);
    // the falling edge that closes our acknowledge window
    assign ack_end = (state == ST_ACK) && ack_drive && events.clk_fall;

    assign load          = ack_end && (ack_next == ST_READ_TX);
    assign tx_byte       = rdata;
    assign data_pull_low = ack_drive || ((state == ST_READ_TX) && !tx_bit);

    always_comb
    begin
        case (state)
            ST_CTRL, ST_ADDR, ST_DATA, ST_ACK:
                shift_mode = eeprom_pkg::SHIFT_RX;
            ST_READ_TX:
                shift_mode = eeprom_pkg::SHIFT_TX;
            default:
                shift_mode = eeprom_pkg::SHIFT_IDLE;
        endcase
    end

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= ST_IDLE;
            ack_next   <= ST_IDLE;
            ack_drive  <= 1'b0;
            addr_valid <= 1'b0;
            block      <= '0;
            addr_lo    <= '0;
            mem_req    <= '0;
        end
        else
        begin
            mem_req.wr_en <= 1'b0;
            mem_req.rd_en <= 1'b0;
            if (events.stop)
            begin
                state      <= ST_IDLE;
                ack_drive  <= 1'b0;
                addr_valid <= 1'b0;
            end
            else if (events.start)
            begin
                // repeated start keeps the address for a random read
                state     <= ST_CTRL;
                ack_drive <= 1'b0;
            end
            else
            begin
                case (state)
                    ST_CTRL:
                    begin
                        if (byte_done)
                        begin
                            if (code_ok && !rx_byte[0])
                            begin
                                block    <= rx_byte[3:1];
                                ack_next <= ST_ADDR;
                                state    <= ST_ACK;
                            end
                            else if (code_ok && addr_valid)
                            begin
                                mem_req.rd_en <= 1'b1;
                                mem_req.addr  <= {rx_byte[3:1], addr_lo};
                                ack_next      <= ST_READ_TX;
                                state         <= ST_ACK;
                            end
                            else
                            begin
                                // not ours, stay off the bus
                                addr_valid <= 1'b0;
                                state      <= ST_IDLE;
                            end
                        end
                    end
                    ST_ADDR:
                    begin
                        if (byte_done)
                        begin
                            addr_lo    <= rx_byte;
                            addr_valid <= 1'b1;
                            ack_next   <= ST_DATA;
                            state      <= ST_ACK;
                        end
                    end
                    ST_DATA:
                    begin
                        if (byte_done)
                        begin
                            mem_req.wr_en <= 1'b1;
                            mem_req.addr  <= {block, addr_lo};
                            mem_req.wdata <= rx_byte;
                            ack_next      <= ST_WAIT_STOP;
                            state         <= ST_ACK;
                        end
                    end
                    ST_ACK:
                    begin
                        // first fall pulls low, second fall releases
                        if (events.clk_fall)
                        begin
                            ack_drive <= !ack_drive;
                            if (ack_drive)
                            begin
                                state <= ack_next;
                            end
                        end
                    end
                    ST_READ_TX:
                    begin
                        // single byte only, host nack then stop
                        if (byte_done)
                        begin
                            state <= ST_WAIT_STOP;
                        end
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    a_idle_quiet: assert property (@(posedge scl) disable iff (!rst_n)
        (state == ST_IDLE) |-> !data_pull_low);

endmodule

`default_nettype wire

// File: hw/eeprom_array.sv
`default_nettype none

module eeprom_array (
    input  wire                        scl,
    input  wire eeprom_pkg::mem_req_t  mem_req,
    output eeprom_pkg::byte_t          rdata
);

    localparam int DEPTH = 1 << $bits(eeprom_pkg::mem_addr_t);

    eeprom_pkg::byte_t mem [0:DEPTH-1];

    always_ff @(posedge scl)
    begin
        if (mem_req.wr_en)
        begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    // registered read, held until the next request
    always_ff @(posedge scl)
    begin
        if (mem_req.rd_en)
        begin
            rdata <= mem[mem_req.addr];
        end
    end

    a_one_access: assert property (@(posedge scl)
        !(mem_req.wr_en && mem_req.rd_en));

endmodule

`default_nettype wire

// File: hw/eeprom_top.sv
`default_nettype none

module eeprom_top #(
    parameter int SYNC_STAGES = 2
) (
    input  wire  scl,
    input  wire  rst_n,
    input  wire  bus_clk,
    input  wire  bus_data,
    output logic data_pull_low
);

    eeprom_pkg::bus_event_t  events;
    eeprom_pkg::shift_mode_t shift_mode;
    logic                    load;
    eeprom_pkg::byte_t       tx_byte;
    eeprom_pkg::byte_t       rx_byte;
    logic                    tx_bit;
    logic                    byte_done;
    eeprom_pkg::mem_req_t    mem_req;
    eeprom_pkg::byte_t       rdata;

    bus_sampler #(
        .SYNC_STAGES (SYNC_STAGES)
    ) sampler_i (
        .scl      (scl),
        .rst_n    (rst_n),
        .bus_clk  (bus_clk),
        .bus_data (bus_data),
        .events   (events)
    );

    byte_shifter shifter_i (
        .scl        (scl),
        .rst_n      (rst_n),
        .events     (events),
        .shift_mode (shift_mode),
        .load       (load),
        .tx_byte    (tx_byte),
        .rx_byte    (rx_byte),
        .tx_bit     (tx_bit),
        .byte_done  (byte_done)
    );

    eeprom_ctrl ctrl_i (
        .scl           (scl),
        .rst_n         (rst_n),
        .events        (events),
        .rx_byte       (rx_byte),
        .tx_bit        (tx_bit),
        .byte_done     (byte_done),
        .rdata         (rdata),
        .shift_mode    (shift_mode),
        .load          (load),
        .tx_byte       (tx_byte),
        .mem_req       (mem_req),
        .data_pull_low (data_pull_low)
    );

    eeprom_array array_i (
        .scl     (scl),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

endmodule

`default_nettype wire

// File: verif/bus_host_tasks.svh
`ifndef BUS_HOST_TASKS_SVH
`define BUS_HOST_TASKS_SVH

// every host change lands shortly after an scl rise
task automatic wait_scl(input int cycles);
    repeat (cycles)
    begin
        @(posedge scl);
    end
    #DRIVE_DLY;
endtask

// data moves in the middle of the low half
task automatic drive_bit(input logic level);
    wait_scl(HALF / 2);
    host_data = level;
    wait_scl(HALF / 2);
    host_clk = 1'b1;
    wait_scl(HALF);
    host_clk = 1'b0;
endtask

// host lets go of the line and reads it at the rise
task automatic sample_bit(output logic level);
    wait_scl(HALF / 2);
    host_data = 1'b1;
    wait_scl(HALF / 2);
    host_clk = 1'b1;
    level = bus_data;
    wait_scl(HALF);
    host_clk = 1'b0;
endtask

// also a repeated start when entered with the clock low
task automatic issue_start();
    wait_scl(HALF / 2);
    host_data = 1'b1;
    wait_scl(HALF / 2);
    host_clk = 1'b1;
    wait_scl(HALF);
    host_data = 1'b0;
    start_seen = 1'b1;
    wait_scl(HALF);
    host_clk = 1'b0;
endtask

task automatic issue_stop();
    wait_scl(HALF / 2);
    host_data = 1'b0;
    wait_scl(HALF / 2);
    host_clk = 1'b1;
    wait_scl(HALF);
    host_data = 1'b1;
    wait_scl(HALF);
endtask

// ack_level is the line at the ninth rise, low when acknowledged
task automatic transmit_byte(input eeprom_pkg::byte_t value, output logic ack_level);
    for (int i = 7; i >= 0; i--)
    begin
        drive_bit(value[i]);
    end
    sample_bit(ack_level);
endtask

// single byte read, host answers with a nack
task automatic receive_byte(output eeprom_pkg::byte_t value);
    logic level;
    value = '0;
    for (int i = 0; i < 8; i++)
    begin
        sample_bit(level);
        value = {value[6:0], level};
    end
    drive_bit(1'b1);
endtask

`endif

// File: verif/eeprom_tb.sv
`default_nettype none

module eeprom_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam time        CLK_PERIOD = 40ns;
    localparam time        DRIVE_DLY  = 2ns;
    // scl cycles per bus clock half period
    localparam int         HALF       = 8;
    // 79 transactions, none longer than 664 scl cycles, stay under 53000
    localparam int         MAX_CYCLES = 60000;
    localparam logic [3:0] CTRL_CODE  = 4'b1010;

    logic  scl;
    logic  rst_n;
    logic  host_clk;
    logic  host_data;
    wire   bus_data;
    logic  data_pull_low;
    logic  start_seen;
    int    cycle_cnt = 0;
    string test_name = "reset";

    eeprom_pkg::byte_t ref_mem [eeprom_pkg::mem_addr_t];

    // open drain, either side may pull low
    assign bus_data = host_data & !data_pull_low;

    eeprom_top dut_i (
        .scl           (scl),
        .rst_n         (rst_n),
        .bus_clk       (host_clk),
        .bus_data      (bus_data),
        .data_pull_low (data_pull_low)
    );

    `include "bus_host_tasks.svh"

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_equal(
        input string      name,
        input logic [7:0] expected,
        input logic [7:0] actual
    );
        assert (actual === expected)
        else
        begin
            abort_run($sformatf("Error %s: expected %02h, actual %02h",
                name, expected, actual));
        end
    endtask

    task automatic check_ack(input string field, input logic ack_level);
        check_equal($sformatf("%s %s ack", test_name, field), 8'h00, {7'b0, ack_level});
    endtask

    task automatic write_location(
        input eeprom_pkg::mem_addr_t addr,
        input eeprom_pkg::byte_t     value
    );
        logic ack_level;
        issue_start();
        transmit_byte({CTRL_CODE, addr[10:8], 1'b0}, ack_level);
        check_ack("control byte", ack_level);
        transmit_byte(addr[7:0], ack_level);
        check_ack("address byte", ack_level);
        transmit_byte(value, ack_level);
        check_ack("data byte", ack_level);
        issue_stop();
        ref_mem[addr] = value;
    endtask

    // random read: address phase, repeated start, one byte back
    task automatic read_location(
        input  eeprom_pkg::mem_addr_t addr,
        output eeprom_pkg::byte_t     value
    );
        logic ack_level;
        issue_start();
        transmit_byte({CTRL_CODE, addr[10:8], 1'b0}, ack_level);
        check_ack("control byte", ack_level);
        transmit_byte(addr[7:0], ack_level);
        check_ack("address byte", ack_level);
        issue_start();
        transmit_byte({CTRL_CODE, addr[10:8], 1'b1}, ack_level);
        check_ack("read control byte", ack_level);
        receive_byte(value);
        issue_stop();
    endtask

    task automatic verify_location(input eeprom_pkg::mem_addr_t addr);
        eeprom_pkg::byte_t got;
        if (!ref_mem.exists(addr))
        begin
            abort_run($sformatf("read of address %03h that was never written", addr));
        end
        else
        begin
            read_location(addr, got);
            check_equal($sformatf("%s read %03h", test_name, addr), ref_mem[addr], got);
        end
    endtask

    initial
    begin
        scl = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) scl = ~scl;
        end
    end

    always @(posedge scl)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            abort_run($sformatf("timeout, no result after %0d scl cycles", MAX_CYCLES));
        end
    end

    a_quiet_until_start: assert property (@(posedge scl) !start_seen |-> !data_pull_low)
    else
    begin
        abort_run("data line pulled low before the first start");
    end

    initial
    begin
        eeprom_pkg::mem_addr_t addr;
        eeprom_pkg::mem_addr_t order [$];
        eeprom_pkg::mem_addr_t swap;
        logic                  ack_level;
        int                    pick;

        void'($urandom(12123));
        rst_n      = 1'b0;
        host_clk   = 1'b1;
        host_data  = 1'b1;
        start_seen = 1'b0;
        repeat (8)
        begin
            @(posedge scl);
        end
        #DRIVE_DLY;
        rst_n = 1'b1;
        wait_scl(HALF);

        // all blocks, both ends of the address byte
        test_name = "write_read";
        for (int k = 0; k < 16; k++)
        begin
            addr = {k[3:1], k[0] ? 8'hff : 8'h00};
            write_location(addr, eeprom_pkg::byte_t'($urandom));
        end
        for (int k = 0; k < 16; k++)
        begin
            verify_location({k[3:1], k[0] ? 8'hff : 8'h00});
        end

        test_name = "code_mismatch";
        issue_start();
        transmit_byte({4'b0110, 3'b010, 1'b0}, ack_level);
        check_equal("code_mismatch write ack level", 8'h01, {7'b0, ack_level});
        issue_stop();
        // wrong code in the read control byte after a valid address phase
        issue_start();
        transmit_byte({CTRL_CODE, 3'b111, 1'b0}, ack_level);
        check_ack("control byte", ack_level);
        transmit_byte(8'h5a, ack_level);
        check_ack("address byte", ack_level);
        issue_start();
        transmit_byte({4'b1011, 3'b111, 1'b1}, ack_level);
        check_equal("code_mismatch read ack level", 8'h01, {7'b0, ack_level});
        issue_stop();
        write_location(11'h2a5, 8'h3c);
        verify_location(11'h2a5);

        // stop right after the address byte, no data phase
        test_name = "early_stop";
        addr = 11'h5c3;
        write_location(addr, 8'ha5);
        issue_start();
        transmit_byte({CTRL_CODE, addr[10:8], 1'b0}, ack_level);
        check_ack("control byte", ack_level);
        transmit_byte(addr[7:0], ack_level);
        check_ack("address byte", ack_level);
        issue_stop();
        verify_location(addr);

        test_name = "random";
        for (int n = 0; n < 20; n++)
        begin
            addr = eeprom_pkg::mem_addr_t'($urandom_range(0, 2047));
            write_location(addr, eeprom_pkg::byte_t'($urandom));
            order.push_back(addr);
        end
        // reads come back in a shuffled order
        for (int i = 19; i > 0; i--)
        begin
            pick        = int'($urandom_range(0, i));
            swap        = order[i];
            order[i]    = order[pick];
            order[pick] = swap;
        end
        foreach (order[i])
        begin
            verify_location(order[i]);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+verif
hw/eeprom_pkg.sv
hw/bus_sampler.sv
hw/byte_shifter.sv
hw/eeprom_ctrl.sv
hw/eeprom_array.sv
hw/eeprom_top.sv
verif/eeprom_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= eeprom_tb
RTL_TOP   ?= eeprom_top
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= -j 0
PASS_MSG  ?= All tests passed

RTL_FILES := $(shell grep '^hw/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert --timescale $(TIMESCALE) $(VFLAGS) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR)
